// ==== verilog/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	// data and address width
	parameter int WORD_SIZE = 16;

	// opcodes, instruction[15:12]
	parameter logic [3:0] BNE_OP = 4'd0;
	parameter logic [3:0] BEQ_OP = 4'd1;
	parameter logic [3:0] BGZ_OP = 4'd2;
	parameter logic [3:0] BLZ_OP = 4'd3;
	parameter logic [3:0] ADI_OP = 4'd4;
	parameter logic [3:0] ORI_OP = 4'd5;
	parameter logic [3:0] LHI_OP = 4'd6;
	parameter logic [3:0] LWD_OP = 4'd7;
	parameter logic [3:0] SWD_OP = 4'd8;
	parameter logic [3:0] JMP_OP = 4'd9;
	parameter logic [3:0] JAL_OP = 4'd10;
	parameter logic [3:0] RTYPE_OP = 4'd15;

	// function codes for RTYPE_OP, instruction[5:0]
	parameter logic [5:0] FUNC_ADD = 6'd0;
	parameter logic [5:0] FUNC_SUB = 6'd1;
	parameter logic [5:0] FUNC_AND = 6'd2;
	parameter logic [5:0] FUNC_ORR = 6'd3;
	parameter logic [5:0] FUNC_NOT = 6'd4;
	parameter logic [5:0] FUNC_TCP = 6'd5;
	parameter logic [5:0] FUNC_SHL = 6'd6;
	parameter logic [5:0] FUNC_SHR = 6'd7;
	parameter logic [5:0] FUNC_JPR = 6'd25;
	parameter logic [5:0] FUNC_JRL = 6'd26;
	parameter logic [5:0] FUNC_WWD = 6'd28;
	parameter logic [5:0] FUNC_HLT = 6'd29;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASSB
	} aluOp_t;

	// memory states have bit 2 set and bits 1..0 below 2
	typedef enum logic [2:0] {
		IF1 = 3'd0,
		IF2 = 3'd1,
		IF3 = 3'd2,
		ID = 3'd3,
		MEM1 = 3'd4,
		MEM2 = 3'd5,
		EX = 3'd6,
		WB = 3'd7
	} microState_t;

	// control word layout, bit 5 is spare
	parameter int CTRL_WIDTH = 13;
	parameter int CTRL_WWD = 12;
	parameter int CTRL_JUMP = 11;
	parameter int CTRL_BRANCH = 10;
	parameter int CTRL_MEMTOREG = 9;
	parameter int CTRL_MEMREAD = 8;
	parameter int CTRL_MEMWRITE = 7;
	parameter int CTRL_REGDST = 6;
	parameter int CTRL_ALUOP_MSB = 4;
	parameter int CTRL_ALUOP_LSB = 1;
	parameter int CTRL_ALUSRC = 0;

endpackage

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire logic [cpuPkg::WORD_SIZE-1:0] a,
	input wire logic [cpuPkg::WORD_SIZE-1:0] b,
	input wire cpuPkg::aluOp_t op,
	output logic [cpuPkg::WORD_SIZE-1:0] result,
	output logic overflow
);

	localparam int MSB = cpuPkg::WORD_SIZE - 1;

	logic [cpuPkg::WORD_SIZE-1:0] sum;
	logic [cpuPkg::WORD_SIZE-1:0] diff;

	assign sum = a + b;
	assign diff = a - b;

	// unary ops work on a only
	always_comb begin
		case (op)
			cpuPkg::ALU_ADD: result = sum;
			cpuPkg::ALU_SUB: result = diff;
			cpuPkg::ALU_AND: result = a & b;
			cpuPkg::ALU_OR: result = a | b;
			cpuPkg::ALU_NOT: result = ~a;
			cpuPkg::ALU_TCP: result = ~a + 1'b1;
			cpuPkg::ALU_SHL: result = {a[MSB-1:0], 1'b0};
			// arithmetic, sign bit kept
			cpuPkg::ALU_SHR: result = {a[MSB], a[MSB:1]};
			cpuPkg::ALU_PASSB: result = b;
			default: result = '0;
		endcase
	end

	// signed overflow of add and sub only
	always_comb begin
		case (op)
			cpuPkg::ALU_ADD: overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			cpuPkg::ALU_SUB: overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			default: overflow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic [1:0] readReg1,
	input wire logic [1:0] readReg2,
	input wire logic [1:0] writeReg,
	input wire logic [cpuPkg::WORD_SIZE-1:0] writeData,
	input wire logic writeEnable,
	output logic [cpuPkg::WORD_SIZE-1:0] readData1,
	output logic [cpuPkg::WORD_SIZE-1:0] readData2
);

	logic [cpuPkg::WORD_SIZE-1:0] regs [4];

	// single write port, one register per cycle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeReg] <= writeData;
		end
	end

	// reads see the old value during a write cycle
	assign readData1 = regs[readReg1];
	assign readData2 = regs[readReg2];

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic [cpuPkg::WORD_SIZE-1:0] instruction,
	output cpuPkg::microState_t microState,
	output logic [cpuPkg::CTRL_WIDTH-1:0] controls,
	output logic halted
);

	logic [3:0] opcode;
	logic [5:0] func;
	logic isHlt;
	logic writesReg;
	cpuPkg::aluOp_t aluSel;
	cpuPkg::microState_t nextState;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];
	assign isHlt = (opcode == cpuPkg::RTYPE_OP) && (func == cpuPkg::FUNC_HLT);

	// decoder, writesReg marks classes that end in WB after EX
	always_comb begin
		controls = '0;
		writesReg = 1'b0;
		aluSel = cpuPkg::ALU_ADD;
		case (opcode)
			cpuPkg::BNE_OP, cpuPkg::BEQ_OP, cpuPkg::BGZ_OP, cpuPkg::BLZ_OP: begin
				// target = incremented pc + imm
				controls[cpuPkg::CTRL_BRANCH] = 1'b1;
				controls[cpuPkg::CTRL_ALUSRC] = 1'b1;
			end
			cpuPkg::ADI_OP, cpuPkg::ORI_OP, cpuPkg::LHI_OP: begin
				controls[cpuPkg::CTRL_ALUSRC] = 1'b1;
				writesReg = 1'b1;
				if (opcode == cpuPkg::ORI_OP) begin
					aluSel = cpuPkg::ALU_OR;
				end else if (opcode == cpuPkg::LHI_OP) begin
					aluSel = cpuPkg::ALU_PASSB;
				end
			end
			cpuPkg::LWD_OP: begin
				controls[cpuPkg::CTRL_MEMREAD] = 1'b1;
				controls[cpuPkg::CTRL_MEMTOREG] = 1'b1;
				controls[cpuPkg::CTRL_ALUSRC] = 1'b1;
			end
			cpuPkg::SWD_OP: begin
				controls[cpuPkg::CTRL_MEMWRITE] = 1'b1;
				controls[cpuPkg::CTRL_ALUSRC] = 1'b1;
			end
			cpuPkg::JMP_OP, cpuPkg::JAL_OP: begin
				controls[cpuPkg::CTRL_JUMP] = 1'b1;
				writesReg = (opcode == cpuPkg::JAL_OP);
			end
			cpuPkg::RTYPE_OP: begin
				case (func)
					cpuPkg::FUNC_ADD, cpuPkg::FUNC_SUB, cpuPkg::FUNC_AND, cpuPkg::FUNC_ORR,
					cpuPkg::FUNC_NOT, cpuPkg::FUNC_TCP, cpuPkg::FUNC_SHL,
					cpuPkg::FUNC_SHR: begin
						controls[cpuPkg::CTRL_REGDST] = 1'b1;
						writesReg = 1'b1;
						// func 0..7 lines up with the first eight ALU ops
						aluSel = cpuPkg::aluOp_t'(func[3:0]);
					end
					cpuPkg::FUNC_JPR, cpuPkg::FUNC_JRL: begin
						controls[cpuPkg::CTRL_JUMP] = 1'b1;
						writesReg = (func == cpuPkg::FUNC_JRL);
					end
					cpuPkg::FUNC_WWD: controls[cpuPkg::CTRL_WWD] = 1'b1;
					default: controls = '0;
				endcase
			end
			default: controls = '0;
		endcase
		controls[cpuPkg::CTRL_ALUOP_MSB:cpuPkg::CTRL_ALUOP_LSB] = aluSel;
	end

	always_comb begin
		nextState = microState;
		case (microState)
			cpuPkg::IF1: nextState = cpuPkg::IF2;
			cpuPkg::IF2: nextState = cpuPkg::IF3;
			cpuPkg::IF3: nextState = cpuPkg::ID;
			cpuPkg::ID: nextState = cpuPkg::EX;
			cpuPkg::EX: begin
				if (controls[cpuPkg::CTRL_MEMREAD] || controls[cpuPkg::CTRL_MEMWRITE]) begin
					nextState = cpuPkg::MEM1;
				end else if (writesReg) begin
					nextState = cpuPkg::WB;
				end else begin
					nextState = cpuPkg::IF1;
				end
			end
			cpuPkg::MEM1: nextState = cpuPkg::MEM2;
			cpuPkg::MEM2: begin
				nextState = controls[cpuPkg::CTRL_MEMREAD] ? cpuPkg::WB : cpuPkg::IF1;
			end
			cpuPkg::WB: nextState = cpuPkg::IF1;
		endcase
	end

	// halted goes high on entry to the EX of HLT and freezes the sequence there
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			microState <= cpuPkg::IF1;
			halted <= 1'b0;
		end else if (!halted) begin
			microState <= nextState;
			if (microState == cpuPkg::ID && isHlt) begin
				halted <= 1'b1;
			end
		end
	end

	// memory states only for loads and stores and EX repeats only while halted
	function automatic logic legalStep(input cpuPkg::microState_t from,
		input cpuPkg::microState_t to, input logic [3:0] op, input logic frozen);
		logic memOp;
		memOp = (op == cpuPkg::LWD_OP) || (op == cpuPkg::SWD_OP);
		case (from)
			cpuPkg::IF1: legalStep = (to == cpuPkg::IF2);
			cpuPkg::IF2: legalStep = (to == cpuPkg::IF3);
			cpuPkg::IF3: legalStep = (to == cpuPkg::ID);
			cpuPkg::ID: legalStep = (to == cpuPkg::EX);
			cpuPkg::EX: begin
				if (frozen) begin
					legalStep = (to == cpuPkg::EX);
				end else if (memOp) begin
					legalStep = (to == cpuPkg::MEM1);
				end else begin
					legalStep = to inside {cpuPkg::WB, cpuPkg::IF1};
				end
			end
			cpuPkg::MEM1: legalStep = (to == cpuPkg::MEM2);
			cpuPkg::MEM2: begin
				legalStep = (to == ((op == cpuPkg::LWD_OP) ? cpuPkg::WB : cpuPkg::IF1));
			end
			cpuPkg::WB: legalStep = (to == cpuPkg::IF1);
			default: legalStep = 1'b0;
		endcase
	endfunction

	stateStepLegal: assert property (@(posedge clk) disable iff (!reset_n)
		reset_n |=> legalStep($past(microState), microState, $past(opcode), $past(halted)));

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input wire logic clk,
	input wire logic reset_n,
	input wire cpuPkg::microState_t microState,
	input wire logic [cpuPkg::CTRL_WIDTH-1:0] controls,
	input wire logic halted,
	input wire logic [cpuPkg::WORD_SIZE-1:0] readData,
	output logic [cpuPkg::WORD_SIZE-1:0] instruction,
	output logic [cpuPkg::WORD_SIZE-1:0] address,
	output logic [cpuPkg::WORD_SIZE-1:0] writeData,
	output logic readM,
	output logic writeM,
	output logic [cpuPkg::WORD_SIZE-1:0] outputPort,
	output logic wwdStrobe
);

	logic [cpuPkg::WORD_SIZE-1:0] pc;
	logic [cpuPkg::WORD_SIZE-1:0] linkPc;
	logic [cpuPkg::WORD_SIZE-1:0] memData;
	logic [3:0] opcode;
	logic [5:0] func;
	logic [7:0] imm;
	logic [1:0] writeReg;
	logic pcStep;
	logic regJump;
	logic isLink;
	logic branchTaken;
	cpuPkg::aluOp_t aluOp;
	logic [cpuPkg::WORD_SIZE-1:0] readData1;
	logic [cpuPkg::WORD_SIZE-1:0] readData2;
	logic [cpuPkg::WORD_SIZE-1:0] immOperand;
	logic [cpuPkg::WORD_SIZE-1:0] aluA;
	logic [cpuPkg::WORD_SIZE-1:0] aluB;
	logic [cpuPkg::WORD_SIZE-1:0] aluResult;
	logic [cpuPkg::WORD_SIZE-1:0] wbData;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];
	assign imm = instruction[7:0];

	// JPR and JRL take their target from rs
	assign regJump = (opcode == cpuPkg::RTYPE_OP) &&
		(func == cpuPkg::FUNC_JPR || func == cpuPkg::FUNC_JRL);
	assign isLink = (opcode == cpuPkg::JAL_OP) ||
		(opcode == cpuPkg::RTYPE_OP && func == cpuPkg::FUNC_JRL);
	assign writeReg = isLink ? 2'd2 :
		controls[cpuPkg::CTRL_REGDST] ? instruction[7:6] : instruction[9:8];

	// LHI goes through the ALU as pass B, ORI is zero extended
	always_comb begin
		case (opcode)
			cpuPkg::LHI_OP: immOperand = {imm, 8'h00};
			cpuPkg::ORI_OP: immOperand = {8'h00, imm};
			default: immOperand = {{8{imm[7]}}, imm};
		endcase
	end

	// ALU doubles as the pc incrementer during IF2 and IF3
	assign pcStep = (microState == cpuPkg::IF2) || (microState == cpuPkg::IF3);
	assign aluOp = pcStep ? cpuPkg::ALU_ADD :
		cpuPkg::aluOp_t'(controls[cpuPkg::CTRL_ALUOP_MSB:cpuPkg::CTRL_ALUOP_LSB]);
	assign aluA = (pcStep || controls[cpuPkg::CTRL_BRANCH]) ? pc : readData1;
	assign aluB = pcStep ? 16'd1 :
		controls[cpuPkg::CTRL_ALUSRC] ? immOperand : readData2;

	always_comb begin
		case (opcode)
			cpuPkg::BNE_OP: branchTaken = (readData1 != readData2);
			cpuPkg::BEQ_OP: branchTaken = (readData1 == readData2);
			cpuPkg::BGZ_OP: branchTaken = !readData1[15] && (readData1 != '0);
			cpuPkg::BLZ_OP: branchTaken = readData1[15];
			default: branchTaken = 1'b0;
		endcase
	end

	assign wbData = controls[cpuPkg::CTRL_MEMTOREG] ? memData :
		isLink ? linkPc : aluResult;

	// fetch uses pc, loads and stores use rs + imm
	assign address = (microState == cpuPkg::IF1 || microState == cpuPkg::IF2) ? pc : aluResult;

	regFile regs (
		.clk(clk),
		.reset_n(reset_n),
		.readReg1(instruction[11:10]),
		.readReg2(instruction[9:8]),
		.writeReg(writeReg),
		.writeData(wbData),
		.writeEnable(microState == cpuPkg::WB),
		.readData1(readData1),
		.readData2(readData2)
	);

	// no overflow trap in this ISA
	alu mainAlu (
		.a(aluA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.overflow()
	);

	// strobes are high in the cycle after the state that requests them
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			instruction <= '0;
			readM <= 1'b0;
			writeM <= 1'b0;
			wwdStrobe <= 1'b0;
			outputPort <= '0;
		end else if (!halted) begin
			readM <= (microState == cpuPkg::IF1) ||
				(microState == cpuPkg::MEM1 && controls[cpuPkg::CTRL_MEMREAD]);
			writeM <= (microState == cpuPkg::MEM1) && controls[cpuPkg::CTRL_MEMWRITE];
			wwdStrobe <= (microState == cpuPkg::IF3) && controls[cpuPkg::CTRL_WWD];
			if (microState == cpuPkg::IF3 && controls[cpuPkg::CTRL_WWD]) begin
				outputPort <= readData1;
			end
			if (microState == cpuPkg::IF2) begin
				instruction <= readData;
			end
			if (microState == cpuPkg::IF3) begin
				pc <= aluResult;
			end else if (microState == cpuPkg::EX) begin
				if (controls[cpuPkg::CTRL_BRANCH] && branchTaken) begin
					pc <= aluResult;
				end else if (controls[cpuPkg::CTRL_JUMP]) begin
					pc <= regJump ? readData1 : {pc[15:12], instruction[11:0]};
				end
			end
		end
	end

	// link value, loaded word and store data
	always_ff @(posedge clk) begin
		if (microState == cpuPkg::EX && controls[cpuPkg::CTRL_JUMP]) begin
			linkPc <= pc;
		end
		if (microState == cpuPkg::MEM2 && controls[cpuPkg::CTRL_MEMREAD]) begin
			memData <= readData;
		end
		if (microState == cpuPkg::MEM1 && controls[cpuPkg::CTRL_MEMWRITE]) begin
			writeData <= readData2;
		end
	end

	memStrobeExclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(readM && writeM));

endmodule

`default_nettype wire

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input wire logic clk,
	input wire logic reset_n,
	// must hold mem[address] before the edge that ends a readM cycle
	input wire logic [cpuPkg::WORD_SIZE-1:0] readData,
	output logic [cpuPkg::WORD_SIZE-1:0] address,
	output logic [cpuPkg::WORD_SIZE-1:0] writeData,
	output logic readM,
	// memory writes on the edge that ends the writeM cycle
	output logic writeM,
	output logic [cpuPkg::WORD_SIZE-1:0] outputPort,
	output logic wwdStrobe,
	output logic halted
);

	logic [cpuPkg::WORD_SIZE-1:0] instruction;
	logic [cpuPkg::CTRL_WIDTH-1:0] controls;
	cpuPkg::microState_t microState;

	controlUnit control (
		.clk(clk),
		.reset_n(reset_n),
		.instruction(instruction),
		.microState(microState),
		.controls(controls),
		.halted(halted)
	);

	datapath dp (
		.clk(clk),
		.reset_n(reset_n),
		.microState(microState),
		.controls(controls),
		.halted(halted),
		.readData(readData),
		.instruction(instruction),
		.address(address),
		.writeData(writeData),
		.readM(readM),
		.writeM(writeM),
		.outputPort(outputPort),
		.wwdStrobe(wwdStrobe)
	);

endmodule

`default_nettype wire

// ==== testbench/tbCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

	localparam int MEM_WORDS = 256;
	localparam int PROG_WORDS = 192;
	localparam int WWD_BASE = 192;
	localparam int WWD_SLOTS = 32;
	localparam int WWD_COUNT_ADDR = 224;
	localparam int PAIR_BASE = 240;
	localparam int PAIR_COUNT = 8;
	// the program loops, so allow several passes over every word
	localparam int CYCLE_LIMIT = 8 * PROG_WORDS * 4 + 200;
	localparam int QUIET_CYCLES = 20;

	logic clk;
	logic reset_n;
	logic [15:0] readData = '0;
	logic [15:0] address;
	logic [15:0] writeData;
	logic readM;
	logic writeM;
	logic [15:0] outputPort;
	logic wwdStrobe;
	logic halted;

	logic [15:0] mem [MEM_WORDS];
	logic [15:0] expectedWwd [WWD_SLOTS];
	logic [15:0] expectedCount;
	logic [15:0] pairAddr [PAIR_COUNT];
	logic [15:0] pairData [PAIR_COUNT];
	logic [15:0] observedWwd [WWD_SLOTS];
	logic [15:0] lastAddress = '0;
	int observedCount = 0;
	int spareStrobes = 0;
	int lateStrobes = 0;
	int lateWrites = 0;
	int badStores = 0;
	int badReads = 0;
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;

	cpuTop dut_i (
		.clk(clk),
		.reset_n(reset_n),
		.readData(readData),
		.address(address),
		.writeData(writeData),
		.readM(readM),
		.writeM(writeM),
		.outputPort(outputPort),
		.wwdStrobe(wwdStrobe),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	// memory answers every edge, store lands on the edge ending the writeM cycle
	// the word on readData belongs to the address seen one edge earlier
	always @(posedge clk) begin
		if (writeM) begin
			if (address[15:8] == 8'h00) begin
				mem[address[7:0]] <= writeData;
			end else begin
				$display("store outside the memory at address %h", address);
				badStores <= badStores + 1;
			end
		end
		if (readM && address !== lastAddress) begin
			$display("read at address %h moved away from address %h", address, lastAddress);
			badReads <= badReads + 1;
		end
		lastAddress <= address;
		readData <= mem[address[7:0]];
	end

	// output port and strobes, sampled mid-cycle
	always @(negedge clk) begin
		if (reset_n) begin
			if (wwdStrobe) begin
				if (halted) begin
					lateStrobes <= lateStrobes + 1;
				end else if (observedCount < WWD_SLOTS) begin
					observedWwd[observedCount] <= outputPort;
					observedCount <= observedCount + 1;
				end else begin
					$display("more output strobes than the expected table holds");
					spareStrobes <= spareStrobes + 1;
				end
			end
			if (writeM && halted) begin
				lateWrites <= lateWrites + 1;
			end
		end
	end

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("error: %s", what);
	endtask

	task automatic closeTest(input string name, input int errorsBefore, input int checksBefore);
		testsRun++;
		if (errorCount != errorsBefore) begin
			testsFailed++;
		end
		$display("test %s: %0d checks, %0d errors", name, checkCount - checksBefore,
			errorCount - errorsBefore);
	endtask

	// program image, then expected outputs, output count and memory pairs
	task automatic loadStimulus();
		$readmemh("testbench/cpu_stimulus.hex", mem);
		for (int i = 0; i < WWD_SLOTS; i++) begin
			expectedWwd[i] = mem[WWD_BASE + i];
		end
		expectedCount = mem[WWD_COUNT_ADDR];
		for (int i = 0; i < PAIR_COUNT; i++) begin
			pairAddr[i] = mem[PAIR_BASE + 2 * i];
			pairData[i] = mem[PAIR_BASE + 2 * i + 1];
		end
	endtask

	task automatic waitForHalt(output logic timedOut);
		timedOut = 1'b0;
		while (!halted && !timedOut) begin
			@(negedge clk);
			if (cycleCount >= CYCLE_LIMIT) begin
				timedOut = 1'b1;
			end
		end
	endtask

	// one slice of the output sequence
	task automatic checkOutputs(input string name, input int first, input int last);
		int errorsBefore;
		int checksBefore;
		errorsBefore = errorCount;
		checksBefore = checkCount;
		for (int i = first; i <= last; i++) begin
			if (i < observedCount) begin
				checkValue($sformatf("%s #%0d", name, i - first), expectedWwd[i], observedWwd[i]);
			end else begin
				reportFailure($sformatf("%s #%0d was never written to the output", name,
					i - first));
			end
		end
		closeTest(name, errorsBefore, checksBefore);
	endtask

	task automatic checkMemory();
		int errorsBefore;
		int checksBefore;
		errorsBefore = errorCount;
		checksBefore = checkCount;
		for (int i = 0; i < PAIR_COUNT; i++) begin
			checkValue($sformatf("memory word %h", pairAddr[i]), pairData[i],
				mem[pairAddr[i][7:0]]);
		end
		closeTest("final memory", errorsBefore, checksBefore);
	endtask

	// core must stay frozen once halted
	task automatic checkHalt();
		int errorsBefore;
		int checksBefore;
		int drops;
		errorsBefore = errorCount;
		checksBefore = checkCount;
		drops = 0;
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			if (!halted) begin
				drops++;
			end
		end
		if (drops != 0) begin
			reportFailure("halted dropped after HLT");
		end
		if (lateWrites != 0) begin
			reportFailure("memory write after the core halted");
		end
		if (lateStrobes != 0) begin
			reportFailure("output strobe after the core halted");
		end
		if (badStores != 0) begin
			reportFailure("the core stored outside the memory");
		end
		if (badReads != 0) begin
			reportFailure("the core moved the address during a memory read");
		end
		checkValue("wwd count", expectedCount, 16'(observedCount + spareStrobes));
		closeTest("output and halt", errorsBefore, checksBefore);
	endtask

	initial begin
		logic timedOut;
		reset_n = 1'b0;
		loadStimulus();
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		waitForHalt(timedOut);
		if (timedOut) begin
			$display("timeout: core never halted");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			// index ranges follow the order of the program
			checkOutputs("alu and immediates", 0, 11);
			checkOutputs("load and store", 12, 14);
			checkOutputs("branches", 15, 20);
			checkOutputs("jumps and links", 21, 24);
			checkMemory();
			checkHalt();
			$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
				testsRun, testsFailed, checkCount, errorCount);
			if (errorCount == 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/cpu_stimulus.hex ====
// program words from address 00, expected output values at c0, output count at e0
// and from f0 on pairs of (address, expected word at that address after halt)
@00
6012 F01C      // lhi r0 12, wwd r0
5034 F01C      // ori r0 r0 34, wwd r0
41FC F41C      // adi r1 r0 -4, wwd r1
4A56 F81C      // adi r2 r2 56, wwd r2
F2C0 FC1C      // add r3 r0 r2, wwd r3
F8C1 FC1C      // sub r3 r2 r0
F3C2 FC1C      // and r3 r0 r3
F6C3 FC1C      // orr r3 r1 r2
F0C4 FC1C      // not r3 r0
F8C5 FC1C      // tcp r3 r2
FCC7 FC1C      // shr r3 r3
F0C6 FC1C      // shl r3 r0
6100 55A0      // r1 = 00a0
8700 8401      // swd r3 [r1+0], swd r0 [r1+1]
7600 F81C      // lwd r2 [r1+0], wwd r2
7701 FC1C      // lwd r3 [r1+1], wwd r3
7602 F81C      // lwd r2 [r1+2] preloaded word
86FF           // swd r2 [r1-1]
6000 6300 4F03 // r0 = 0, r3 = 3
4001 F01C 03FD // loop: adi r0 r0 1, wwd r0, bne r0 r3 loop
1301 F41C      // beq r0 r3 taken, skipped wwd
1101 F01C      // beq r0 r1 not taken, wwd r0
2001 F41C      // bgz r0 taken, skipped wwd
F085 2801 F81C // tcp r2 r0, bgz r2 not taken, wwd r2
3801 F41C      // blz r2 taken, skipped wwd
3001 F01C      // blz r0 not taken, wwd r0
9039 F41C F41C // jmp 039 over two wwd
A046 FC1C      // jal 046, wwd r3 after return
6100 554B F41A // r1 = 004b, jrl r1
F81C F01D      // wwd r2, hlt
F01C 8700      // past the halt
@46 F81C 4F10 F819 // wwd r2, adi r3 r3 10, jpr r2
@4B F81C 8610 F819 // wwd r2, swd r2 [r1+10], jpr r2
@A2 BEEF
@C0
1200 1234 1230 0056 128A EE22 0220 1276 EDCB FFAA FFD5 2468
2468 1234 BEEF
0001 0002 0003 0003 FFFD 0003
003A 0013 003E 003E
@E0 0019
@F0
00A0 2468
00A1 1234
009F BEEF
00A2 BEEF
005B 003E
004B F81C
0040 F01C
0041 8700

// ==== filelist.f ====
verilog/cpuPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/cpuTop.sv
testbench/tbCpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tbCpu
RTL_TOP := cpuTop
FILELIST := filelist.f
BUILD_DIR := obj_dir
LOG := sim.log
VFLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
